//--- Makefile
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module mem_stage_tb

sim:
	verilator --binary --timing --assert -f sources.f --top-module mem_stage_tb \
		-o Vmem_stage_tb
	-./obj_dir/Vmem_stage_tb 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

//--- hw/data_ram.sv
`timescale 1ns/100ps

`include "mem_defs.svh"

module data_ram (
    input  logic                       clk,
    input  logic                       en,
    input  logic [3:0]                 we,
    input  logic [`MEM_ADDR_WIDTH-1:0] addr,
    input  logic [`MEM_DATA_WIDTH-1:0] wdata,
    output logic [`MEM_DATA_WIDTH-1:0] rdata
);

    logic [`MEM_DATA_WIDTH-1:0] mem [0:`MEM_DEPTH-1];

    // byte-lane writes
    always_ff @(posedge clk) begin
        if (en && (we != 4'b0000)) begin
            for (int i = 0; i < `MEM_LANES; i++) begin
                if (we[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // read register only loads on a read, holds through stalls
    always_ff @(posedge clk) begin
        if (en && (we == 4'b0000)) begin
            rdata <= mem[addr];
        end
    end

endmodule

//--- hw/lsu1c.sv
`timescale 1ns/100ps

`include "mem_defs.svh"

module lsu1c (
    input  mem_pkg::ex_mem_t            req,
    input  logic                        accept,
    output logic                        ram_en,
    output logic [3:0]                  ram_we,
    output logic [`MEM_ADDR_WIDTH-1:0]  ram_addr,
    output logic [`MEM_DATA_WIDTH-1:0]  ram_wdata,
    output logic                        is_data_adel,
    output logic                        is_data_ades
);

    logic [1:0] a;
    logic       is_store;
    logic       half_op;
    logic       word_op;
    logic       store_ok;
    logic [3:0] lane_mask;

    assign a = req.ls_addr[1:0];

    // halfword and word accesses need natural alignment
    assign half_op = (req.ls_sel == mem_pkg::LH) || (req.ls_sel == mem_pkg::LHU) ||
                     (req.ls_sel == mem_pkg::SH);
    assign word_op = (req.ls_sel == mem_pkg::LW) || (req.ls_sel == mem_pkg::SW);

    assign is_store = (req.ls_sel == mem_pkg::SB)  || (req.ls_sel == mem_pkg::SH)  ||
                      (req.ls_sel == mem_pkg::SW)  || (req.ls_sel == mem_pkg::SWL) ||
                      (req.ls_sel == mem_pkg::SWR);

    always_comb begin
        is_data_adel = 1'b0;
        is_data_ades = 1'b0;
        if (req.ls_ena && ((half_op && a[0]) || (word_op && (a != 2'b00)))) begin
            if (is_store) begin
                is_data_ades = 1'b1;
            end else begin
                is_data_adel = 1'b1;
            end
        end
    end

    // place store data into its byte lanes
    always_comb begin
        lane_mask = 4'b0000;
        ram_wdata = req.rt_data;
        case (req.ls_sel)
            mem_pkg::SB: begin
                lane_mask = 4'b0001 << a;
                ram_wdata = {4{req.rt_data[7:0]}};
            end
            mem_pkg::SH: begin
                lane_mask = 4'b0011 << a;
                ram_wdata = {2{req.rt_data[15:0]}};
            end
            mem_pkg::SW: begin
                lane_mask = 4'b1111;
                ram_wdata = req.rt_data;
            end
            mem_pkg::SWL: begin
                // lanes 0..a take the top a+1 bytes of rt
                lane_mask = 4'b1111 >> (2'd3 - a);
                ram_wdata = req.rt_data >> (8 * (2'd3 - a));
            end
            mem_pkg::SWR: begin
                // lanes a..3 take the low 4-a bytes of rt
                lane_mask = 4'b1111 << a;
                ram_wdata = req.rt_data << (8 * a);
            end
            default: begin
                lane_mask = 4'b0000;
            end
        endcase
    end

    // faulting or already excepted stores must not touch memory
    assign store_ok = is_store && !is_data_ades && !req.has_exception;

    assign ram_en   = accept && req.ls_ena;
    assign ram_we   = (ram_en && store_ok) ? lane_mask : 4'b0000;
    assign ram_addr = req.ls_addr[`MEM_ADDR_WIDTH+1:2];

endmodule

//--- hw/lsu2c.sv
`timescale 1ns/100ps

module lsu2c (
    input  mem_pkg::ex_mem_t item,
    input  logic             is_data_adel,
    input  logic             is_data_ades,
    input  logic [31:0]      rdata,
    output mem_pkg::mem_wb_t wb
);

    logic [1:0]  a;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic [31:0] load_data;
    logic        fault;

    assign a        = item.ls_addr[1:0];
    assign sel_byte = rdata[8*a +: 8];
    assign sel_half = a[1] ? rdata[31:16] : rdata[15:0];
    assign fault    = is_data_adel || is_data_ades;

    always_comb begin
        load_data = 32'h0;
        case (item.ls_sel)
            mem_pkg::LB: begin
                load_data = {{24{sel_byte[7]}}, sel_byte};
            end
            mem_pkg::LBU: begin
                load_data = {24'h0, sel_byte};
            end
            mem_pkg::LH: begin
                load_data = {{16{sel_half[15]}}, sel_half};
            end
            mem_pkg::LHU: begin
                load_data = {16'h0, sel_half};
            end
            mem_pkg::LW: begin
                load_data = rdata;
            end
            mem_pkg::LWL: begin
                // low a+1 ram bytes go to the top, rt keeps the rest
                case (a)
                    2'd0:    load_data = {rdata[7:0],  item.rt_data[23:0]};
                    2'd1:    load_data = {rdata[15:0], item.rt_data[15:0]};
                    2'd2:    load_data = {rdata[23:0], item.rt_data[7:0]};
                    default: load_data = rdata;
                endcase
            end
            mem_pkg::LWR: begin
                // top 4-a ram bytes go to the bottom
                case (a)
                    2'd0:    load_data = rdata;
                    2'd1:    load_data = {item.rt_data[31:24], rdata[31:8]};
                    2'd2:    load_data = {item.rt_data[31:16], rdata[31:16]};
                    default: load_data = {item.rt_data[31:8],  rdata[31:24]};
                endcase
            end
            default: begin
                // stores return nothing
                load_data = 32'h0;
            end
        endcase
    end

    always_comb begin
        wb.pc            = item.pc;
        wb.alu_res       = item.alu_res;
        wb.r_data        = (item.ls_ena && !fault) ? load_data : 32'h0;
        wb.w_reg_ena     = item.w_reg_ena;
        wb.w_reg_dst     = item.w_reg_dst;
        wb.wb_reg_sel    = item.wb_reg_sel;
        wb.is_data_adel  = is_data_adel;
        wb.is_data_ades  = is_data_ades;
        wb.has_exception = item.has_exception || fault;
    end

endmodule

//--- hw/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// word-address bits of the local data RAM
// the RAM index is taken from ls_addr[MEM_ADDR_WIDTH+1:2]
`define MEM_ADDR_WIDTH 10

// data word size, also the store data width
`define MEM_DATA_WIDTH 32

// byte lanes per data word
`define MEM_LANES (`MEM_DATA_WIDTH / 8)

// number of words held by the data RAM
`define MEM_DEPTH (1 << `MEM_ADDR_WIDTH)

`endif

//--- hw/mem_pkg.sv
package mem_pkg;

    // load/store operation select
    typedef enum logic [3:0] {
        LB  = 4'd0,
        LBU = 4'd1,
        LH  = 4'd2,
        LHU = 4'd3,
        LW  = 4'd4,
        LWL = 4'd5,
        LWR = 4'd6,
        SB  = 4'd7,
        SH  = 4'd8,
        SW  = 4'd9,
        SWL = 4'd10,
        SWR = 4'd11
    } ls_sel_e;

    // executed instruction handed over from execute
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] alu_res;
        logic [31:0] ls_addr;
        logic [31:0] rt_data;
        logic        w_reg_ena;
        logic [4:0]  w_reg_dst;
        logic        ls_ena;
        ls_sel_e     ls_sel;
        logic        wb_reg_sel;
        logic        has_exception;
    } ex_mem_t;

    // result handed over to writeback
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] alu_res;
        logic [31:0] r_data;
        logic        w_reg_ena;
        logic [4:0]  w_reg_dst;
        logic        wb_reg_sel;
        logic        is_data_adel;
        logic        is_data_ades;
        logic        has_exception;
    } mem_wb_t;

endpackage

//--- hw/mem_stage.sv
`timescale 1ns/100ps

`include "mem_defs.svh"

module mem_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    output logic             in_ready,
    input  mem_pkg::ex_mem_t in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output mem_pkg::mem_wb_t out_data
);

    logic                       accept;
    logic                       valid_q;
    mem_pkg::ex_mem_t           item_q;
    logic                       adel_q;
    logic                       ades_q;

    logic                       ram_en;
    logic [3:0]                 ram_we;
    logic [`MEM_ADDR_WIDTH-1:0] ram_addr;
    logic [`MEM_DATA_WIDTH-1:0] ram_wdata;
    logic [`MEM_DATA_WIDTH-1:0] ram_rdata;
    logic                       adel;
    logic                       ades;

    // a new item may enter as the held one leaves
    assign in_ready  = !valid_q || out_ready;
    assign accept    = in_valid && in_ready;
    assign out_valid = valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    // stage payload, loaded with the ram access
    always_ff @(posedge clk) begin
        if (accept) begin
            item_q <= in_data;
            adel_q <= adel;
            ades_q <= ades;
        end
    end

    lsu1c u_lsu1c (
        .req          (in_data),
        .accept       (accept),
        .ram_en       (ram_en),
        .ram_we       (ram_we),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata),
        .is_data_adel (adel),
        .is_data_ades (ades)
    );

    data_ram u_data_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    lsu2c u_lsu2c (
        .item         (item_q),
        .is_data_adel (adel_q),
        .is_data_ades (ades_q),
        .rdata        (ram_rdata),
        .wb           (out_data)
    );

endmodule

//--- sim/mem_stage_properties.sv
`timescale 1ns/100ps

module mem_stage_properties (
    input logic             clk,
    input logic             rst,
    input logic             in_valid,
    input logic             in_ready,
    input logic             out_valid,
    input logic             out_ready,
    input mem_pkg::mem_wb_t out_data
);

    // a stalled result stays put until the sink takes it
    hold_when_stalled: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("out_data or out_valid changed during a stall");

    quiet_in_reset: assert property (@(posedge clk)
        rst |=> !out_valid)
        else $error("out_valid high after a reset cycle");

    // single register stage
    valid_after_accept: assert property (@(posedge clk) disable iff (rst)
        (in_valid && in_ready && out_ready) |=> out_valid)
        else $error("no out_valid one cycle after an accept");

endmodule

bind mem_stage mem_stage_properties u_properties (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
);

//--- sim/mem_stage_tb.sv
`timescale 1ns/100ps

module mem_stage_tb;

    localparam int FILL_ITEMS   = 64;
    localparam int RAND_ITEMS   = 1000;
    localparam int NUM_ITEMS    = FILL_ITEMS + RAND_ITEMS;
    localparam int RESET_CYCLES = 10;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_ITEMS * 20) * 10;

    logic             clk;
    logic             rst;
    logic             in_valid;
    logic             in_ready;
    logic             out_valid;
    logic             out_ready;
    mem_pkg::ex_mem_t in_data;
    mem_pkg::mem_wb_t out_data;

    logic [31:0]      rng_state = 32'd88785;
    logic [7:0]       model_mem [0:255];
    mem_pkg::mem_wb_t exp_q [$];
    int               errors;
    int               received;

    tb_clock u_clock (.clk(clk));

    mem_stage UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // first items fill the 64-word window with SW, the rest are random
    function automatic mem_pkg::ex_mem_t make_item(input int idx);
        mem_pkg::ex_mem_t it;
        logic [31:0]      r;
        logic [31:0]      addr;
        r    = next_random();
        addr = next_random();
        it.pc         = 32'h0040_0000 + (32'(idx) << 2);
        it.alu_res    = next_random();
        it.rt_data    = next_random();
        it.w_reg_ena  = r[16];
        it.w_reg_dst  = r[12:8];
        it.wb_reg_sel = r[17];
        if (idx < FILL_ITEMS) begin
            it.ls_addr       = {addr[31:12], 4'h0, 6'(idx), 2'b00};
            it.ls_ena        = 1'b1;
            it.ls_sel        = mem_pkg::SW;
            it.has_exception = 1'b0;
        end else begin
            it.ls_addr       = {addr[31:12], 4'h0, addr[7:0]};
            it.ls_ena        = r[18] | r[19];
            it.ls_sel        = mem_pkg::ls_sel_e'(r[3:0] % 4'd12);
            it.has_exception = (r[7:4] == 4'd0);
        end
        return it;
    endfunction

    function automatic mem_pkg::mem_wb_t expect_result(input mem_pkg::ex_mem_t it);
        mem_pkg::mem_wb_t e;
        logic [7:0]       ram_b [4];
        logic [7:0]       res_b [4];
        logic [15:0]      half;
        logic             is_store;
        logic             misaligned;
        int               a;
        int               base;
        a    = int'(it.ls_addr[1:0]);
        base = int'(it.ls_addr[7:2]) * 4;
        for (int k = 0; k < 4; k++) begin
            ram_b[k] = model_mem[base + k];
            res_b[k] = it.rt_data[8*k +: 8];
        end
        half     = {ram_b[(a & 2) + 1], ram_b[a & 2]};
        is_store = it.ls_sel inside {mem_pkg::SB, mem_pkg::SH, mem_pkg::SW,
                                     mem_pkg::SWL, mem_pkg::SWR};
        misaligned = ((it.ls_sel inside {mem_pkg::LH, mem_pkg::LHU, mem_pkg::SH}) &&
                      it.ls_addr[0]) ||
                     ((it.ls_sel inside {mem_pkg::LW, mem_pkg::SW}) && (a != 0));
        e.pc            = it.pc;
        e.alu_res       = it.alu_res;
        e.w_reg_ena     = it.w_reg_ena;
        e.w_reg_dst     = it.w_reg_dst;
        e.wb_reg_sel    = it.wb_reg_sel;
        e.is_data_adel  = it.ls_ena && misaligned && !is_store;
        e.is_data_ades  = it.ls_ena && misaligned && is_store;
        e.has_exception = it.has_exception || e.is_data_adel || e.is_data_ades;
        case (it.ls_sel)
            mem_pkg::LB:  e.r_data = {{24{ram_b[a][7]}}, ram_b[a]};
            mem_pkg::LBU: e.r_data = {24'h0, ram_b[a]};
            mem_pkg::LH:  e.r_data = {{16{half[15]}}, half};
            mem_pkg::LHU: e.r_data = {16'h0, half};
            mem_pkg::LW:  e.r_data = {ram_b[3], ram_b[2], ram_b[1], ram_b[0]};
            mem_pkg::LWL: begin
                for (int k = 0; k <= a; k++) begin
                    res_b[3 - a + k] = ram_b[k];
                end
                e.r_data = {res_b[3], res_b[2], res_b[1], res_b[0]};
            end
            mem_pkg::LWR: begin
                for (int k = a; k < 4; k++) begin
                    res_b[k - a] = ram_b[k];
                end
                e.r_data = {res_b[3], res_b[2], res_b[1], res_b[0]};
            end
            default: e.r_data = 32'h0;
        endcase
        if (!it.ls_ena || misaligned) begin
            e.r_data = 32'h0;
        end
        return e;
    endfunction

    task automatic apply_store(input mem_pkg::ex_mem_t it);
        int a;
        int base;
        a    = int'(it.ls_addr[1:0]);
        base = int'(it.ls_addr[7:2]) * 4;
        if (it.ls_ena && !it.has_exception) begin
            case (it.ls_sel)
                mem_pkg::SB: model_mem[base + a] = it.rt_data[7:0];
                mem_pkg::SH: begin
                    if (!it.ls_addr[0]) begin
                        model_mem[base + a]     = it.rt_data[7:0];
                        model_mem[base + a + 1] = it.rt_data[15:8];
                    end
                end
                mem_pkg::SW: begin
                    for (int k = 0; k < 4; k++) begin
                        if (a == 0) model_mem[base + k] = it.rt_data[8*k +: 8];
                    end
                end
                mem_pkg::SWL: begin
                    for (int k = 0; k <= a; k++) begin
                        model_mem[base + k] = it.rt_data[8*(3 - a + k) +: 8];
                    end
                end
                mem_pkg::SWR: begin
                    for (int k = a; k < 4; k++) begin
                        model_mem[base + k] = it.rt_data[8*(k - a) +: 8];
                    end
                end
                default: begin
                end
            endcase
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_result(input mem_pkg::mem_wb_t got, input mem_pkg::mem_wb_t exp);
        check_value("out_data.pc", got.pc, exp.pc);
        check_value("out_data.alu_res", got.alu_res, exp.alu_res);
        check_value("out_data.r_data", got.r_data, exp.r_data);
        check_value("out_data.w_reg_ena", 32'(got.w_reg_ena), 32'(exp.w_reg_ena));
        check_value("out_data.w_reg_dst", 32'(got.w_reg_dst), 32'(exp.w_reg_dst));
        check_value("out_data.wb_reg_sel", 32'(got.wb_reg_sel), 32'(exp.wb_reg_sel));
        check_value("out_data.is_data_adel", 32'(got.is_data_adel), 32'(exp.is_data_adel));
        check_value("out_data.is_data_ades", 32'(got.is_data_ades), 32'(exp.is_data_ades));
        check_value("out_data.has_exception", 32'(got.has_exception),
                    32'(exp.has_exception));
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: %0d of %0d items came out", received, NUM_ITEMS);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        mem_pkg::mem_wb_t held_out;
        logic             stalled;
        logic             took;
        logic             gave;
        int               next_idx;
        errors    = 0;
        received  = 0;
        next_idx  = 0;
        stalled   = 1'b0;
        took      = 1'b0;
        held_out  = '0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            assert (out_valid === 1'b0) else begin
                $display("out_valid went high during reset");
                errors++;
            end
        end
        rst = 1'b0;
        #4;
        assert (out_valid === 1'b0 && in_ready === 1'b1) else begin
            $display("stage not empty and ready right after reset");
            errors++;
        end
        while (received < NUM_ITEMS) begin
            @(negedge clk);
            if (took) begin
                in_valid = 1'b0;
            end
            if (!in_valid && next_idx < NUM_ITEMS && (next_random() % 32'd4 != 32'd0)) begin
                in_data  = make_item(next_idx);
                in_valid = 1'b1;
                next_idx++;
            end
            out_ready = (next_random() % 32'd4 != 32'd0);
            // sample just before the rising edge where everything has settled
            #4;
            // one stage, so it is full exactly while one accepted item is pending
            check_value("out_valid", 32'(out_valid), 32'(exp_q.size() != 0));
            check_value("in_ready", 32'(in_ready), 32'((exp_q.size() == 0) || out_ready));
            if (stalled) begin
                assert (out_valid === 1'b1 && out_data === held_out) else begin
                    $display("held result changed while the output was stalled");
                    errors++;
                end
            end
            stalled  = out_valid && !out_ready;
            held_out = out_data;
            gave     = out_valid && out_ready;
            took     = in_valid && in_ready;
            if (gave) begin
                assert (exp_q.size() != 0) else begin
                    $display("output transfer with no accepted item pending");
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    compare_result(out_data, exp_q.pop_front());
                end
                received++;
            end
            if (took) begin
                exp_q.push_back(expect_result(in_data));
                apply_store(in_data);
            end
        end
        $display("items checked: %0d, errors: %0d", received, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter int HALF_PERIOD = 5
) (
    output logic clk
);

    // 10 ns period, first rising edge at 5 ns
    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

//--- sources.f
+incdir+hw
hw/mem_pkg.sv
hw/lsu1c.sv
hw/data_ram.sv
hw/lsu2c.sv
hw/mem_stage.sv
sim/tb_clock.sv
sim/mem_stage_properties.sv
sim/mem_stage_tb.sv
